/* logic/cache_pkg.sv */
package cache_pkg;

	// Address split of a 16-bit word address.
	localparam int TAG_WIDTH = 9;
	localparam int SET_WIDTH = 3;
	localparam int OFFSET_WIDTH = 3;
	localparam int WORD_WIDTH = 16;
	localparam int WORDS_PER_LINE = 1 << OFFSET_WIDTH;
	localparam int LINE_ADDR_WIDTH = TAG_WIDTH + SET_WIDTH;

	typedef logic [WORD_WIDTH-1:0] word_t;

	// Eight words, word 0 in the low bits.
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

	typedef logic way_t;

	// Bit 0 is never used, the memory being word-addressed.
	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		logic [SET_WIDTH-1:0] set;
		logic [OFFSET_WIDTH-1:0] offset;
		logic unused;
	} addr_t;

	typedef enum logic [1:0] {
		idle_lookup,
		write_back,
		line_fill
	} cache_state_t;

	// One line transfer toward physical memory.
	typedef struct packed {
		logic [LINE_ADDR_WIDTH-1:0] line_addr;
		line_t wdata;
	} pmem_req_t;

endpackage

/* logic/cache_control.sv */
module cache_control (
	input logic clk,
	input logic reset_miss,
	input logic mem_read,
	input logic mem_write,
	input logic hit,
	input logic victim_dirty,
	input logic pmem_resp,
	output logic mem_resp,
	output logic tag_load,
	output logic dirty_set,
	output logic dirty_clear,
	output logic lru_update,
	output logic data_word_write,
	output logic data_line_fill,
	output logic pmem_read,
	output logic pmem_write,
	output logic use_victim_addr,
	output logic hit_event,
	output logic miss_event
);

	import cache_pkg::*;

	cache_state_t state, next_state;
	logic request;

	assign request = mem_read | mem_write;

	always_ff @(posedge clk or posedge reset_miss) begin
		if (reset_miss)
			state <= idle_lookup;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			idle_lookup: begin
				if (request && !hit) begin
					// A dirty victim has to reach memory before it is replaced.
					if (victim_dirty)
						next_state = write_back;
					else
						next_state = line_fill;
				end
			end
			write_back: begin
				if (pmem_resp)
					next_state = line_fill;
			end
			line_fill: begin
				if (pmem_resp)
					next_state = idle_lookup;
			end
			default: next_state = idle_lookup;
		endcase
	end

	always_comb begin
		mem_resp = 1'b0;
		tag_load = 1'b0;
		dirty_set = 1'b0;
		dirty_clear = 1'b0;
		lru_update = 1'b0;
		data_word_write = 1'b0;
		data_line_fill = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		use_victim_addr = 1'b0;
		hit_event = 1'b0;
		miss_event = 1'b0;

		case (state)
			idle_lookup: begin
				if (request && hit) begin
					mem_resp = 1'b1;
					lru_update = 1'b1;
					hit_event = 1'b1;
					if (mem_write) begin
						data_word_write = 1'b1;
						dirty_set = 1'b1;
					end
				end
			end
			write_back: begin
				pmem_write = 1'b1;
				use_victim_addr = 1'b1; // Victim tag goes out.
			end
			line_fill: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					// Line arrives, so tag, valid and data are written together.
					tag_load = 1'b1;
					dirty_clear = 1'b1;
					data_line_fill = 1'b1;
					miss_event = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

/* logic/cache_tag_store.sv */
module cache_tag_store #(
	parameter int NUM_SETS = 8
) (
	input logic clk,
	input logic reset_miss,
	input cache_pkg::addr_t addr,
	input logic tag_load,
	input logic dirty_set,
	input logic dirty_clear,
	input logic lru_update,
	output logic hit,
	output cache_pkg::way_t hit_way,
	output cache_pkg::way_t victim_way,
	output logic victim_dirty,
	output logic [cache_pkg::TAG_WIDTH-1:0] victim_tag
);

	import cache_pkg::*;

	logic [TAG_WIDTH-1:0] tag_q [NUM_SETS][2];
	logic [1:0] valid_q [NUM_SETS];
	logic [1:0] dirty_q [NUM_SETS];
	logic lru_q [NUM_SETS]; // Names the way to evict next.

	logic [1:0] match;
	logic [1:0] set_valid;
	way_t act_way;

	assign set_valid = valid_q[addr.set];
	assign match[0] = set_valid[0] && (tag_q[addr.set][0] == addr.tag);
	assign match[1] = set_valid[1] && (tag_q[addr.set][1] == addr.tag);

	assign hit = |match;
	assign hit_way = match[1];

	// An empty way is filled before anything is evicted.
	always_comb begin
		if (!set_valid[0])
			victim_way = 1'b0;
		else if (!set_valid[1])
			victim_way = 1'b1;
		else
			victim_way = lru_q[addr.set];
	end

	assign victim_dirty = dirty_q[addr.set][victim_way];
	assign victim_tag = tag_q[addr.set][victim_way];
	assign act_way = hit ? hit_way : victim_way;

	always_ff @(posedge clk) begin
		if (tag_load)
			tag_q[addr.set][act_way] <= addr.tag;
	end

	always_ff @(posedge clk or posedge reset_miss) begin
		if (reset_miss) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				valid_q[i] <= 2'b00;
				dirty_q[i] <= 2'b00;
				lru_q[i] <= 1'b0;
			end
		end else begin
			if (tag_load)
				valid_q[addr.set][act_way] <= 1'b1;
			if (dirty_set)
				dirty_q[addr.set][act_way] <= 1'b1;
			else if (dirty_clear)
				dirty_q[addr.set][act_way] <= 1'b0;
			if (lru_update)
				lru_q[addr.set] <= ~act_way; // Point at the other way.
		end
	end

endmodule

/* logic/cache_data_store.sv */
module cache_data_store #(
	parameter int NUM_SETS = 8
) (
	input logic clk,
	input cache_pkg::addr_t addr,
	input cache_pkg::way_t way,
	input cache_pkg::word_t wdata,
	input logic word_write,
	input logic line_fill,
	input cache_pkg::line_t fill_line,
	output cache_pkg::word_t rdata,
	output cache_pkg::line_t victim_line
);

	import cache_pkg::*;

	line_t lines_q [NUM_SETS][2];

	always_ff @(posedge clk) begin
		if (line_fill)
			lines_q[addr.set][way] <= fill_line;
		else if (word_write)
			lines_q[addr.set][way][addr.offset] <= wdata;
	end

	// Whole line of the selected way, used for write-back.
	assign victim_line = lines_q[addr.set][way];

	assign rdata = victim_line[addr.offset];

endmodule

/* logic/cache_stats.sv */
module cache_stats #(
	parameter int COUNT_WIDTH = 16
) (
	input logic clk,
	input logic reset_miss,
	input logic clear_stats,
	input logic hit_event,
	input logic miss_event,
	output logic [COUNT_WIDTH-1:0] hit_count,
	output logic [COUNT_WIDTH-1:0] miss_count
);

	logic hit_full;
	logic miss_full;

	assign hit_full = &hit_count;
	assign miss_full = &miss_count;

	always_ff @(posedge clk or posedge reset_miss) begin
		if (reset_miss) begin
			hit_count <= '0;
			miss_count <= '0;
		end else if (clear_stats) begin
			hit_count <= '0;
			miss_count <= '0;
		end else begin
			if (hit_event && !hit_full)
				hit_count <= hit_count + 1'b1;
			if (miss_event && !miss_full)
				miss_count <= miss_count + 1'b1; // Holds at all ones.
		end
	end

endmodule

/* logic/cache_top.sv */
module cache_top #(
	parameter int NUM_SETS = 1 << cache_pkg::SET_WIDTH,
	parameter int COUNT_WIDTH = 16
) (
	input logic clk,
	input logic reset_miss,
	input logic mem_read,
	input logic mem_write,
	input cache_pkg::addr_t mem_address,
	input cache_pkg::word_t mem_wdata,
	output cache_pkg::word_t mem_rdata,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output cache_pkg::pmem_req_t pmem_req,
	input cache_pkg::line_t pmem_rdata,
	input logic pmem_resp,
	input logic clear_stats,
	output logic [COUNT_WIDTH-1:0] hit_count,
	output logic [COUNT_WIDTH-1:0] miss_count
);

	import cache_pkg::*;

	logic hit;
	way_t hit_way;
	way_t victim_way;
	way_t access_way;
	logic victim_dirty;
	logic [TAG_WIDTH-1:0] victim_tag;
	line_t victim_line;
	logic tag_load, dirty_set, dirty_clear, lru_update;
	logic data_word_write, data_line_fill;
	logic use_victim_addr;
	logic hit_event, miss_event;

	assign access_way = hit ? hit_way : victim_way;

	// Write-back goes to the victim's address, a fill to the requested one.
	assign pmem_req.line_addr = use_victim_addr ? {victim_tag, mem_address.set}
	                                            : {mem_address.tag, mem_address.set};
	assign pmem_req.wdata = victim_line;

	cache_control control_i (
		.clk, .reset_miss, .mem_read, .mem_write, .hit, .victim_dirty, .pmem_resp,
		.mem_resp, .tag_load, .dirty_set, .dirty_clear, .lru_update,
		.data_word_write, .data_line_fill, .pmem_read, .pmem_write,
		.use_victim_addr, .hit_event, .miss_event
	);

	cache_tag_store #(.NUM_SETS(NUM_SETS)) tag_store_i (
		.clk, .reset_miss, .addr(mem_address), .tag_load, .dirty_set, .dirty_clear,
		.lru_update, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
	);

	cache_data_store #(.NUM_SETS(NUM_SETS)) data_store_i (
		.clk, .addr(mem_address), .way(access_way), .wdata(mem_wdata),
		.word_write(data_word_write), .line_fill(data_line_fill),
		.fill_line(pmem_rdata), .rdata(mem_rdata), .victim_line
	);

	cache_stats #(.COUNT_WIDTH(COUNT_WIDTH)) stats_i (
		.clk, .reset_miss, .clear_stats, .hit_event, .miss_event,
		.hit_count, .miss_count
	);

endmodule

/* testbench/cache_props.sv */
module cache_props (
	input logic clk,
	input logic reset_miss,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic mem_resp,
	input cache_pkg::cache_state_t state
);

	timeunit 1ns;
	timeprecision 100ps;

	import cache_pkg::*;

	int error_count = 0;

	// One line transfer at a time.
	read_write_exclusive: assert property (
		@(posedge clk) disable iff (reset_miss) !(pmem_read && pmem_write)
	) else begin
		$error("pmem_read and pmem_write are high together");
		error_count++;
	end

	read_held: assert property (
		@(posedge clk) disable iff (reset_miss) (pmem_read && !pmem_resp) |=> pmem_read
	) else begin
		$error("pmem_read dropped before pmem_resp");
		error_count++;
	end

	write_held: assert property (
		@(posedge clk) disable iff (reset_miss) (pmem_write && !pmem_resp) |=> pmem_write
	) else begin
		$error("pmem_write dropped before pmem_resp");
		error_count++;
	end

	resp_in_lookup: assert property (
		@(posedge clk) disable iff (reset_miss) mem_resp |-> (state == idle_lookup)
	) else begin
		$error("mem_resp is high outside idle_lookup");
		error_count++;
	end

endmodule

bind cache_control cache_props props_i (
	.clk(clk),
	.reset_miss(reset_miss),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.mem_resp(mem_resp),
	.state(state)
);

/* testbench/cache_tb.sv */
module cache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import cache_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int MAX_TESTS = 64;
	localparam int CYCLES_PER_TEST = 40;

	logic clk;
	logic reset_miss;
	logic mem_read;
	logic mem_write;
	addr_t mem_address;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	pmem_req_t pmem_req;
	line_t pmem_rdata;
	logic pmem_resp;
	logic clear_stats;
	logic [15:0] hit_count;
	logic [15:0] miss_count;

	string test_name [MAX_TESTS];
	string test_op [MAX_TESTS];
	logic [15:0] test_addr [MAX_TESTS];
	logic [15:0] test_data [MAX_TESTS];
	logic [15:0] test_exp [MAX_TESTS];
	int num_tests = 0;
	int pass_count = 0;
	int fail_count = 0;
	int assert_errors = 0;
	logic tests_loaded = 1'b0;

	line_t mem_lines [1 << LINE_ADDR_WIDTH]; // Physical memory with one entry per line.
	integer seed = 32'h61d5;
	int mem_delay;
	pmem_req_t mem_req;

	cache_top #(.NUM_SETS(8), .COUNT_WIDTH(16)) cache_top_i (
		.clk, .reset_miss, .mem_read, .mem_write, .mem_address, .mem_wdata,
		.mem_rdata, .mem_resp, .pmem_read, .pmem_write, .pmem_req, .pmem_rdata,
		.pmem_resp, .clear_stats, .hit_count, .miss_count
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic load_tests();
		int fd;
		int fields;
		int status;
		string line;
		string name;
		string op;
		logic [15:0] addr;
		logic [15:0] data;
		logic [15:0] exp;
		fd = $fopen("testbench/cache_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the tests file testbench/cache_tests.txt");
			fail_count++;
		end else begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				line = "";
				status = $fgets(line, fd);
				fields = 0;
				if (status > 0 && line.getc(0) != "#")
					fields = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, exp);
				if (fields == 5) begin
					test_name[num_tests] = name;
					test_op[num_tests] = op;
					test_addr[num_tests] = addr;
					test_data[num_tests] = data;
					test_exp[num_tests] = exp;
					num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		reset_miss = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		reset_miss = 1'b0;
	endtask

	task automatic note_pass(input string name);
		$display("pass %s", name);
		pass_count++;
	endtask

	// Holds one CPU request until mem_resp is seen at a falling edge.
	task automatic cpu_access(input logic write, input addr_t addr, input word_t data,
			output word_t rdata);
		mem_address = addr;
		mem_wdata = data;
		mem_read = !write;
		mem_write = write;
		@(negedge clk);
		while (!mem_resp)
			@(negedge clk);
		rdata = mem_rdata;
		@(posedge clk);
		#2;
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic run_test(input int i);
		word_t rdata;
		if (test_op[i] == "read") begin
			cpu_access(1'b0, test_addr[i], 16'h0000, rdata);
			if (rdata !== test_exp[i]) begin
				$display("** Error %s: expected %h, actual %h", test_name[i], test_exp[i], rdata);
				fail_count++;
			end else
				note_pass(test_name[i]);
		end else if (test_op[i] == "write") begin
			cpu_access(1'b1, test_addr[i], test_data[i], rdata);
			note_pass(test_name[i]);
		end else if (test_op[i] == "stats") begin
			@(negedge clk);
			if (hit_count !== test_data[i] || miss_count !== test_exp[i]) begin
				$display("** Error %s: expected hits %0d misses %0d, actual hits %0d misses %0d",
					test_name[i], test_data[i], test_exp[i], hit_count, miss_count);
				fail_count++;
			end else
				note_pass(test_name[i]);
			@(posedge clk);
			#2;
		end else if (test_op[i] == "clear") begin
			clear_stats = 1'b1;
			@(posedge clk);
			#2;
			clear_stats = 1'b0;
			note_pass(test_name[i]);
		end else if (test_op[i] == "reset") begin
			apply_reset();
			note_pass(test_name[i]);
		end else begin
			$display("Test %s has an unknown operation %s", test_name[i], test_op[i]);
			fail_count++;
		end
	endtask

	// Memory model with a random response delay of 1 to 4 cycles.
	initial begin
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		for (int l = 0; l < (1 << LINE_ADDR_WIDTH); l++)
			for (int w = 0; w < WORDS_PER_LINE; w++)
				mem_lines[l][w] = 16'((l << 4) | (w << 1)) ^ 16'hA5A5;
		forever begin
			@(negedge clk);
			if (pmem_read || pmem_write) begin
				mem_delay = ($unsigned($random(seed)) % 4) + 1;
				repeat (mem_delay) @(posedge clk);
				#2;
				mem_req = pmem_req;
				if (pmem_write)
					mem_lines[mem_req.line_addr] = mem_req.wdata; // Write-back lands here.
				else
					pmem_rdata = mem_lines[mem_req.line_addr];
				pmem_resp = 1'b1;
				@(posedge clk);
				#2;
				pmem_resp = 1'b0;
			end
		end
	end

	initial begin
		wait (tests_loaded);
		repeat (num_tests * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog expired before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset_miss = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		clear_stats = 1'b0;
		load_tests();
		tests_loaded = 1'b1;
		apply_reset();
		for (int i = 0; i < num_tests; i++)
			run_test(i);
		assert_errors = cache_top_i.control_i.props_i.error_count;
		$display("%0d tests, %0d passed, %0d failed, %0d assertion errors",
			num_tests, pass_count, fail_count, assert_errors);
		if (fail_count == 0 && assert_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* testbench/cache_tests.txt */
# Columns: name op address data expected, all numbers in hex.
# A stats line holds the expected hit count in data and the expected miss count in expected.
cold_read          read  0012 0000 a5b7
stats_cold         stats 0000 0001 0001
same_line_read     read  001e 0000 a5bb
write_hit          write 0014 1234 0000
readback_hit       read  0014 0000 1234
stats_hits         stats 0000 0004 0001
second_tag_fill    read  0090 0000 a535
first_tag_hit      read  0014 0000 1234
third_tag_evict    read  0110 0000 a4b5
stats_evict        stats 0000 0007 0003
mru_hit            read  0112 0000 a4b7
survivor_hit       read  0016 0000 a5b3
stats_mru          stats 0000 0009 0003
evicted_miss       read  0092 0000 a537
stats_evicted      stats 0000 000a 0004
dirty_evict        read  0110 0000 a4b5
written_back       read  0014 0000 1234
stats_dirty        stats 0000 000c 0006
clear_counts       clear 0000 0000 0000
stats_cleared      stats 0000 0000 0000
reset_cache        reset 0000 0000 0000
read_after_reset   read  0014 0000 1234
stats_reset        stats 0000 0001 0001
write_miss         write 0240 beef 0000
write_miss_read    read  0240 0000 beef
write_miss_other   read  0242 0000 a7e7
stats_final        stats 0000 0004 0002

/* build.f */
logic/cache_pkg.sv
logic/cache_control.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_stats.sv
logic/cache_top.sv
testbench/cache_props.sv
testbench/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - files:
      - logic/cache_pkg.sv
      - logic/cache_control.sv
      - logic/cache_tag_store.sv
      - logic/cache_data_store.sv
      - logic/cache_stats.sv
      - logic/cache_top.sv
  - target: test
    files:
      - testbench/cache_props.sv
      - testbench/cache_tb.sv
